//--- Makefile
TOP := fetch_cache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f fetch_cache.f

sim:
	verilator --binary --timing --top-module $(TOP) -f fetch_cache.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- fetch_cache.f
rtl/fetch_pkg.sv
rtl/cache_pkg.sv
rtl/fetch_if.sv
rtl/result_if.sv
rtl/pc_sequencer.sv
rtl/i_cache.sv
rtl/fetch_output.sv
rtl/fetch_cache_top.sv
sim/fetch_cache_tb.sv

//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    import fetch_pkg::*;

    // Word address bits, the low two bits are always zero
    typedef logic [31:2] tag_t;

    // One cache entry holds a single instruction word
    typedef struct packed {
        logic   valid;
        tag_t   tag;
        instr_t data;
    } cache_line_t;

    // Miss handling controller
    typedef enum logic [1:0] {
        idle         = 2'd0,  // Lookups accepted
        fetch_mem    = 2'd1,  // Waiting on the memory
        update_cache = 2'd2   // Refill line write
    } cache_state_t;

endpackage

`default_nettype wire

//--- rtl/fetch_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_cache_top
    import fetch_pkg::*;
#(
    parameter int NUM_BLOCKS = 8
)(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   run,
    input  wire logic   redirect,
    input  wire addr_t  redirect_pc,
    input  wire instr_t mem_data,
    input  wire logic   mem_valid,
    output logic        instr_valid,
    output instr_t      instr,
    output addr_t       instr_pc,
    output logic        instr_hit,
    output logic [31:0] hit_count,
    output logic [31:0] miss_count,
    output logic        mem_req,
    output addr_t       mem_addr
);

    fetch_if  fetch_bus ();   // Sequencer to cache
    result_if result_bus ();  // Cache to output stage

    pc_sequencer u_pc_sequencer (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch       (fetch_bus.sequencer)
    );

    i_cache #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) u_i_cache (
        .clk       (clk),
        .rst       (rst),
        .fetch     (fetch_bus.cache),
        .result    (result_bus.cache),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mem_valid (mem_valid)
    );

    fetch_output u_fetch_output (
        .clk         (clk),
        .rst         (rst),
        .result      (result_bus.sink),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_hit   (instr_hit),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

endmodule

`default_nettype wire

//--- rtl/fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_if
    import fetch_pkg::*;
();

    logic  fetch_req;  // Lookup strobe, taken in the same cycle
    addr_t pc;         // Address of the requested word
    logic  ready;      // Cache controller is idle

    modport sequencer (
        output fetch_req,
        output pc,
        input  ready
    );

    modport cache (
        input  fetch_req,
        input  pc,
        output ready
    );

endinterface

`default_nettype wire

//--- rtl/fetch_output.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_output
    import fetch_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    result_if.sink      result,
    output logic        instr_valid,
    output instr_t      instr,
    output addr_t       instr_pc,
    output logic        instr_hit,
    output logic [31:0] hit_count,
    output logic [31:0] miss_count
);

    // Valid strobe and statistics
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr_valid <= 1'b0;
            hit_count   <= '0;
            miss_count  <= '0;
        end else begin
            instr_valid <= result.res_valid;
            if (result.res_valid) begin
                if (result.res_hit) begin
                    hit_count <= hit_count + 32'd1;  // Wraps at 32 bits
                end else begin
                    miss_count <= miss_count + 32'd1;
                end
            end
        end
    end

    // Payload only moves with a valid result
    always_ff @(posedge clk) begin
        if (result.res_valid) begin
            instr     <= result.res_instr;
            instr_pc  <= result.res_pc;
            instr_hit <= result.res_hit;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Byte address into the instruction space
    typedef logic [31:0] addr_t;

    // One instruction word
    typedef logic [31:0] instr_t;

    // First address fetched out of reset
    localparam addr_t RESET_PC = 32'h0000_0000;

    // Fetch addresses always step by one word
    localparam addr_t PC_STEP = 32'd4;

endpackage

`default_nettype wire

//--- rtl/i_cache.sv
`timescale 1ns/1ps
`default_nettype none

module i_cache
    import fetch_pkg::*;
    import cache_pkg::*;
#(
    parameter int NUM_BLOCKS = 8
)(
    input  wire logic   clk,
    input  wire logic   rst,
    fetch_if.cache      fetch,
    result_if.cache     result,
    output logic        mem_req,
    output addr_t       mem_addr,
    input  wire instr_t mem_data,
    input  wire logic   mem_valid
);

    localparam int IDX_W = $clog2(NUM_BLOCKS);
    localparam int LRU_W = $clog2(NUM_BLOCKS);  // Counters span 0 to NUM_BLOCKS-1

    cache_line_t        lines [NUM_BLOCKS];
    logic [LRU_W-1:0]   lru   [NUM_BLOCKS];     // Zero is most recently used

    cache_state_t       state;

    tag_t               req_tag;
    logic               hit;
    logic [IDX_W-1:0]   hit_idx;
    instr_t             hit_data;

    logic               free_found;
    logic [IDX_W-1:0]   victim;
    logic [LRU_W-1:0]   oldest_age;

    logic               touch_en;
    logic [IDX_W-1:0]   touch_idx;
    logic [LRU_W-1:0]   touch_age;

    addr_t              miss_pc;
    instr_t             fill_data;

    assign req_tag     = fetch.pc[31:2];
    assign fetch.ready = (state == idle);
    assign mem_addr    = miss_pc;

    // Parallel tag match, the lowest matching index is used
    always_comb begin
        hit      = 1'b0;
        hit_idx  = '0;
        hit_data = '0;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            if (!hit && lines[i].valid && lines[i].tag == req_tag) begin
                hit      = 1'b1;
                hit_idx  = IDX_W'(i);
                hit_data = lines[i].data;
            end
        end
    end

    // Refill target: first free line, else the oldest with lowest index on ties
    always_comb begin
        free_found = 1'b0;
        victim     = '0;
        oldest_age = lru[0];
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            if (!free_found && !lines[i].valid) begin
                free_found = 1'b1;
                victim     = IDX_W'(i);
            end else if (!free_found && lru[i] > oldest_age) begin
                oldest_age = lru[i];
                victim     = IDX_W'(i);
            end
        end
    end

    // Line being made most recent on a hit or a fill
    always_comb begin
        touch_en  = 1'b0;
        touch_idx = victim;
        if (state == idle && fetch.fetch_req && hit) begin
            touch_en  = 1'b1;
            touch_idx = hit_idx;
        end else if (state == update_cache) begin
            touch_en  = 1'b1;
        end
    end

    // A free line counts as older than every valid one so all valid lines age
    assign touch_age = lines[touch_idx].valid ? lru[touch_idx] : '1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state            <= idle;
            mem_req          <= 1'b0;
            result.res_valid <= 1'b0;
        end else begin
            result.res_valid <= 1'b0;
            case (state)
                idle: begin
                    if (fetch.fetch_req) begin
                        if (hit) begin
                            result.res_valid <= 1'b1;
                        end else begin
                            state   <= fetch_mem;
                            mem_req <= 1'b1;
                        end
                    end
                end
                fetch_mem: begin
                    if (mem_valid) begin
                        state            <= update_cache;
                        mem_req          <= 1'b0;
                        result.res_valid <= 1'b1;  // Word goes out before the line write
                    end
                end
                update_cache: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && fetch.fetch_req) begin
            result.res_instr <= hit_data;
            result.res_pc    <= fetch.pc;
            result.res_hit   <= hit;
            if (!hit) begin
                miss_pc <= fetch.pc;  // Held for the whole refill
            end
        end else if (state == fetch_mem && mem_valid) begin
            result.res_instr <= mem_data;
            result.res_pc    <= miss_pc;
            result.res_hit   <= 1'b0;
            fill_data        <= mem_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_BLOCKS; i++) begin
                lines[i].valid <= 1'b0;
                lru[i]         <= '0;
            end
        end else begin
            if (state == update_cache) begin
                lines[victim] <= '{valid: 1'b1, tag: miss_pc[31:2], data: fill_data};
            end

            // Only lines younger than the touched one move back a place
            if (touch_en) begin
                for (int j = 0; j < NUM_BLOCKS; j++) begin
                    if (IDX_W'(j) == touch_idx) begin
                        lru[j] <= '0;
                    end else if (lines[j].valid && lru[j] < touch_age) begin
                        lru[j] <= lru[j] + LRU_W'(1);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer
    import fetch_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     run,
    input  wire logic     redirect,
    input  wire addr_t    redirect_pc,
    fetch_if.sequencer    fetch
);

    logic  issue;
    addr_t pc_q;      // Next sequential address
    logic  pend;      // Redirect waiting for the next issue
    addr_t pend_pc;

    // Issue whenever the cache can take a lookup
    assign issue = run && fetch.ready;

    assign fetch.fetch_req = issue;

    // A pending redirect replaces the sequential address
    assign fetch.pc = pend ? pend_pc : pc_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= RESET_PC;
            pend <= 1'b0;
        end else begin
            if (issue) begin
                pc_q <= fetch.pc + PC_STEP;
            end

            // New redirect beats clearing by an issue in the same cycle
            if (redirect) begin
                pend <= 1'b1;
            end else if (issue) begin
                pend <= 1'b0;
            end
        end
    end

    // Latest target wins if several redirects land before an issue
    always_ff @(posedge clk) begin
        if (redirect) begin
            pend_pc <= redirect_pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/result_if.sv
`timescale 1ns/1ps
`default_nettype none

interface result_if
    import fetch_pkg::*;
();

    logic   res_valid;  // One pulse per completed fetch
    instr_t res_instr;
    addr_t  res_pc;
    logic   res_hit;    // Low when the word came from memory

    modport cache (
        output res_valid,
        output res_instr,
        output res_pc,
        output res_hit
    );

    modport sink (
        input res_valid,
        input res_instr,
        input res_pc,
        input res_hit
    );

endinterface

`default_nettype wire

//--- sim/fetch_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_cache_tb
    import fetch_pkg::*;
();

    localparam int NUM_BLOCKS   = 8;
    localparam int INPUT_WORDS  = 256;
    localparam int QUIET_CYCLES = 8;  // Longer than any gap inside a refill

    logic        clk;
    logic        rst;
    logic        run;
    logic        redirect;
    addr_t       redirect_pc;
    instr_t      mem_data;
    logic        mem_valid;
    logic        instr_valid;
    instr_t      instr;
    addr_t       instr_pc;
    logic        instr_hit;
    logic [31:0] hit_count;
    logic [31:0] miss_count;
    logic        mem_req;
    addr_t       mem_addr;

    logic [31:0] input_words [INPUT_WORDS];
    instr_t      mem_image [addr_t];
    int          redir_after [$];
    addr_t       redir_target [$];
    int          end_after;
    int          cycle_limit;
    int          cycles;

    // Reference copy of the cache contents and LRU order
    logic        m_valid [NUM_BLOCKS];
    addr_t       m_addr  [NUM_BLOCKS];
    int          m_age   [NUM_BLOCKS];

    addr_t       exp_pc;  // Next sequential address expected
    int          results_seen;
    int          redirects_done;
    int          redirects_used;
    int          model_hits;
    int          model_misses;
    logic        last_was_hit;
    logic        run_d1;
    logic        run_d2;

    fetch_cache_top #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) u_fetch_cache_top (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_data    (mem_data),
        .mem_valid   (mem_valid),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_hit   (instr_hit),
        .hit_count   (hit_count),
        .miss_count  (miss_count),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure();
        $display("STATUS: FAIL");
        $fatal(1, "fetch_cache_tb halted on error");
    endtask

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %08h actual %08h", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %08h actual %08h", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0b actual %0b", $time, name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
            report_failure();
        end
    endtask

    // Unlisted addresses read back as their own inverse
    function automatic instr_t image_word(input addr_t a);
        return mem_image.exists(a) ? mem_image[a] : ~a;
    endfunction

    function automatic addr_t next_pc();
        return (redirects_used < redirects_done) ? redir_target[redirects_used] : exp_pc;
    endfunction

    function automatic int model_find(input addr_t pc);
        int found;
        found = -1;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            if (found < 0 && m_valid[i] && m_addr[i][31:2] == pc[31:2]) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic model_access(input addr_t pc, output logic hit);
        int idx;
        int old_age;
        idx = model_find(pc);
        hit = (idx >= 0);
        for (int i = NUM_BLOCKS - 1; i >= 0; i--) begin
            if (!hit && !m_valid[i]) begin
                idx = i;  // Lowest free line ends up chosen
            end
        end
        if (idx < 0) begin
            idx = 0;
            for (int i = 1; i < NUM_BLOCKS; i++) begin
                if (m_age[i] > m_age[idx]) begin
                    idx = i;
                end
            end
        end
        // A free line ranks behind every valid one
        old_age = m_valid[idx] ? m_age[idx] : NUM_BLOCKS;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            if (i == idx) begin
                m_age[i] = 0;
            end else if (m_valid[i] && m_age[i] < old_age) begin
                m_age[i]++;
            end
        end
        m_valid[idx] = 1'b1;
        m_addr[idx]  = pc;
    endtask

    task automatic load_input();
        int i;
        end_after = -1;
        for (i = 0; i < INPUT_WORDS; i++) begin
            input_words[i] = '1;
        end
        $readmemh("sim/fetch_input.txt", input_words);
        i = 0;
        while (end_after < 0 && i + 2 < INPUT_WORDS) begin
            case (input_words[i])
                32'd0: mem_image[input_words[i + 1]] = input_words[i + 2];
                32'd1: begin
                    redir_after.push_back(int'(input_words[i + 1]));
                    redir_target.push_back(input_words[i + 2]);
                end
                32'd2: end_after = int'(input_words[i + 1]);
                default: i = INPUT_WORDS;  // Unknown record ends the scan
            endcase
            i += 3;
        end
        if (end_after < 0) begin
            $display("Input file sim/fetch_input.txt has no valid end record");
            report_failure();
        end
    endtask

    task automatic wait_results(input int count);
        do @(posedge clk); while (results_seen < count);
    endtask

    // Returns once no result and no refill has been seen for a while
    task automatic drain();
        int quiet;
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);
            quiet = (instr_valid || mem_req) ? 0 : quiet + 1;
        end
    endtask

    // External instruction memory with random latency
    initial begin : memory_model
        integer seed;
        int     wait_cycles;
        int     phase;
        addr_t  req_addr;
        seed        = 32'hdb54_9d04;
        mem_valid   = 1'b0;
        mem_data    = '0;
        wait_cycles = 0;
        phase       = 0;
        req_addr    = '0;
        forever begin
            @(posedge clk);
            mem_valid <= 1'b0;
            if (rst) begin
                phase = 0;
            end else begin
                if (phase == 0 && mem_req) begin
                    req_addr    = mem_addr;
                    wait_cycles = 1 + ($unsigned($random(seed)) % 6);
                    phase       = 1;
                end
                if (phase == 1) begin
                    wait_cycles--;
                    if (wait_cycles == 0) begin
                        mem_valid <= 1'b1;
                        mem_data  <= image_word(req_addr);
                        phase      = 2;
                    end
                end else if (phase == 2 && !mem_req) begin
                    phase = 0;  // Request dropped, ready for the next miss
                end
            end
        end
    end

    always @(negedge clk) begin : monitor
        addr_t pc_e;
        logic  hit_e;
        hit_e = 1'b0;
        if (rst) begin
            for (int i = 0; i < NUM_BLOCKS; i++) begin
                m_valid[i] = 1'b0;
                m_addr[i]  = '0;
                m_age[i]   = 0;
            end
            exp_pc         = RESET_PC;
            results_seen   = 0;
            redirects_used = 0;
            model_hits     = 0;
            model_misses   = 0;
            last_was_hit   = 1'b0;
            run_d1         = 1'b0;
            run_d2         = 1'b0;
        end else begin
            // Hit issued right behind a hit comes out on the next cycle
            if (last_was_hit && run_d2 && model_find(next_pc()) >= 0) begin
                check_flag("instr_valid", 1'b1, instr_valid);
            end
            if (instr_valid) begin
                pc_e = next_pc();
                if (redirects_used < redirects_done) begin
                    redirects_used++;
                end
                model_access(pc_e, hit_e);
                check_addr("instr_pc", pc_e, instr_pc);
                check_instr("instr", image_word(pc_e), instr);
                check_flag("instr_hit", hit_e, instr_hit);
                if (hit_e) begin
                    model_hits++;
                end else begin
                    model_misses++;
                end
                exp_pc = pc_e + 32'd4;
                results_seen++;
            end
            last_was_hit = instr_valid && hit_e;
            if (mem_req) begin  // Refill only for the next fetch and only on a miss
                check_flag("mem_req", model_find(next_pc()) < 0, mem_req);
                check_addr("mem_addr", next_pc(), mem_addr);
            end
            run_d2 = run_d1;
            run_d1 = run;
        end
    end

    initial begin : watchdog
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles before the last expected result", cycles);
        report_failure();
    end

    initial begin : control
        rst            = 1'b1;
        run            = 1'b0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        redirects_done = 0;
        load_input();
        cycle_limit = 200 * (end_after + 1);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        run <= 1'b1;
        for (int r = 0; r < redir_after.size(); r++) begin
            wait_results(redir_after[r]);
            run <= 1'b0;
            drain();
            @(posedge clk);
            redirect    <= 1'b1;
            redirect_pc <= redir_target[r];
            redirects_done++;
            @(posedge clk);
            redirect <= 1'b0;
            run      <= 1'b1;
        end
        wait_results(end_after);
        run <= 1'b0;
        drain();
        @(posedge clk);
        check_count("hit_count", 32'(model_hits), hit_count);
        check_count("miss_count", 32'(model_misses), miss_count);
        if (model_hits == 0 || model_misses == 0) begin
            $display("Stimulus did not produce both hits and misses");
            report_failure();
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/fetch_input.txt
// kind  addr_or_count  word_or_target  (all hex)
// kind 0 memory word, 1 redirect after that many results, 2 end after that many results
// straight-line code from reset
0 00000000 00000013
0 00000004 00100093
0 00000008 00200113
0 0000000c 002081b3
0 00000010 00418213
0 00000014 0000006f
// short loop body at 0x100
0 00000100 06400293
0 00000104 fff28293
0 00000108 00028463
0 0000010c ff9ff06f
0 00000110 00512023
0 00000114 00012303
0 00000118 00630333
0 0000011c 0063a023
// long loop body at 0x200
0 00000200 20000537
0 00000204 00452583
0 00000208 00852603
0 0000020c 00c52683
0 00000210 00b60733
0 00000214 00d707b3
0 00000218 00f52823
0 0000021c 01452803
0 00000220 0105a8b3
0 00000224 01152a23
// redirects and end of run
1 00000004 00000100
1 00000009 00000100
1 0000000e 00000100
1 00000013 00000100
1 00000018 00000200
1 00000022 00000200
1 0000002c 00000200
1 00000036 00000100
2 0000003e 00000000
